// File: bench/tb_working_memory_bank.sv
`include "gbc_wram_params.svh"

module tb_working_memory_bank
   import gbc_wram_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   // run limit well above the summed test length.
   localparam int TIMEOUT_CYCLES = 20000;
   // longest wait on a single handshake.
   localparam int WAIT_LIMIT = 200;
   localparam int BURST_LEN = 32;

   logic        i_clk;
   logic        rst_n;
   logic [15:0] io_addr;
   logic [7:0]  io_wdata;
   logic        io_we;
   logic        io_re;
   logic [7:0]  io_rdata;
   logic        dmg_mode;
   logic        req_valid;
   logic        req_ready;
   logic [15:0] req_addr;
   logic        req_we;
   logic [7:0]  req_wdata;
   logic        resp_valid;
   logic        resp_ready;
   logic [7:0]  resp_rdata;

   integer      seed;
   int          cycle_cnt = 0;
   // own copy of the bank state.
   bank_t       tb_bank;
   logic        tb_dmg;
   // reference memory indexed by physical address.
   logic [7:0]  ref_mem [`WRAM_DEPTH];
   // expected read data in request order.
   logic [7:0]  exp_q [$];

   working_memory_bank UUT (
      .i_clk      (i_clk),
      .rst_n      (rst_n),
      .io_addr    (io_addr),
      .io_wdata   (io_wdata),
      .io_we      (io_we),
      .io_re      (io_re),
      .io_rdata   (io_rdata),
      .dmg_mode   (dmg_mode),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_addr   (req_addr),
      .req_we     (req_we),
      .req_wdata  (req_wdata),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_rdata (resp_rdata)
   );

   // 20 ns clock.
   always #10 i_clk = ~i_clk;

   // run limit.
   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("simulation timed out after %0d cycles", cycle_cnt);
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
   endtask

   // logical to physical address by the address map.
   function automatic phys_addr_t model_addr(input logic [15:0] addr);
      bank_t b;
      // 0xc000 window is always bank 0.
      if (!addr[12]) begin
         return {3'd0, addr[11:0]};
      end
      b = tb_dmg ? bank_t'(1) : tb_bank;
      // bank 0 selects bank 1.
      if (b == bank_t'(0)) begin
         b = bank_t'(1);
      end
      return {b, addr[11:0]};
   endfunction

   task automatic set_mode(input logic dmg);
      dmg_mode = dmg;
      tb_dmg = dmg;
   endtask

   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      io_addr = addr;
      io_wdata = data;
      io_we = 1'b1;
      @(posedge i_clk);
      #2;
      io_we = 1'b0;
      // dmg mode ignores svbk writes.
      if (addr == `SVBK_ADDR && !tb_dmg) begin
         tb_bank = data[2:0];
      end
   endtask

   // read-back is registered and valid one cycle after io_re.
   task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
      io_addr = addr;
      io_re = 1'b1;
      @(posedge i_clk);
      #2;
      io_re = 1'b0;
      data = io_rdata;
   endtask

   // hold the request until it transfers.
   task automatic send_request(input logic [15:0] addr, input logic we,
                               input logic [7:0] data);
      int   waits;
      logic taken;
      waits = 0;
      taken = 1'b0;
      req_valid = 1'b1;
      req_addr = addr;
      req_we = we;
      req_wdata = data;
      while (!taken) begin
         // sampled mid-cycle once the drive has settled.
         @(negedge i_clk);
         taken = req_ready;
         @(posedge i_clk);
         #2;
         waits++;
         if (!taken && waits > WAIT_LIMIT) begin
            abort_run("a request was never accepted");
         end
      end
      req_valid = 1'b0;
   endtask

   task automatic wram_write(input logic [15:0] addr, input logic [7:0] data);
      send_request(addr, 1'b1, data);
      ref_mem[model_addr(addr)] = data;
   endtask

   task automatic wram_read(input logic [15:0] addr, output logic [7:0] data);
      int   waits;
      logic got;
      resp_ready = 1'b1;
      send_request(addr, 1'b0, 8'h00);
      waits = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge i_clk);
         got = resp_valid;
         data = resp_rdata;
         @(posedge i_clk);
         #2;
         waits++;
         if (!got && waits > WAIT_LIMIT) begin
            abort_run("no read response arrived");
         end
      end
   endtask

   task automatic check_read(input logic [15:0] addr);
      logic [7:0] rd;
      wram_read(addr, rd);
      check_value("resp_rdata", rd, ref_mem[model_addr(addr)]);
   endtask

   task automatic reset_defaults();
      logic [7:0] rd;
      check_value("resp_valid", {7'd0, resp_valid}, 8'h00);
      check_value("req_ready", {7'd0, req_ready}, 8'h01);
      check_value("io_rdata", io_rdata, 8'h00);
      // bank 0 with the upper bits set.
      io_read(`SVBK_ADDR, rd);
      check_value("io_rdata", rd, 8'hF8);
   endtask

   task automatic svbk_readback();
      logic [7:0] rd;
      set_mode(1'b0);
      for (int v = 0; v < `WRAM_BANKS; v++) begin
         // junk in bits 7:3 must not stick.
         io_write(`SVBK_ADDR, {5'b10110, v[2:0]});
         io_read(`SVBK_ADDR, rd);
         check_value("io_rdata", rd, {5'b11111, v[2:0]});
      end
      // another io address.
      io_write(16'hFF4F, 8'h02);
      io_read(`SVBK_ADDR, rd);
      check_value("io_rdata", rd, {5'b11111, tb_bank});
   endtask

   task automatic bank_isolation();
      integer     rnd;
      logic [7:0] base;
      set_mode(1'b0);
      // fixed window first.
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         wram_write(16'hC000 | {12'd0, i[3:0]}, rnd[7:0]);
      end
      rnd = $random(seed);
      base = rnd[7:0];
      // bank and offset in the low bits keep each byte distinct.
      for (int b = 1; b < `WRAM_BANKS; b++) begin
         io_write(`SVBK_ADDR, {5'd0, b[2:0]});
         for (int i = 0; i < 16; i++) begin
            wram_write(16'hD000 | {12'd0, i[3:0]}, base ^ {1'b0, b[2:0], i[3:0]});
         end
      end
      // bank 0 reads the bank 1 bytes.
      for (int b = 0; b < `WRAM_BANKS; b++) begin
         io_write(`SVBK_ADDR, {5'd0, b[2:0]});
         for (int i = 0; i < 16; i++) begin
            check_read(16'hD000 | {12'd0, i[3:0]});
         end
      end
      for (int i = 0; i < 16; i++) begin
         check_read(16'hC000 | {12'd0, i[3:0]});
      end
   endtask

   task automatic dmg_bank_lock();
      integer     rnd;
      logic [7:0] rd;
      logic [7:0] pattern;
      set_mode(1'b0);
      io_write(`SVBK_ADDR, 8'h04);
      set_mode(1'b1);
      rnd = $random(seed);
      pattern = rnd[7:0];
      wram_write(16'hD123, pattern);
      io_write(`SVBK_ADDR, 8'h05);
      wram_read(16'hD123, rd);
      check_value("resp_rdata", rd, pattern);
      io_write(`SVBK_ADDR, 8'h06);
      wram_read(16'hD123, rd);
      check_value("resp_rdata", rd, pattern);
      // stored bank untouched.
      io_read(`SVBK_ADDR, rd);
      check_value("io_rdata", rd, {5'b11111, tb_bank});
      // bank 1 bytes from earlier show through.
      check_read(16'hD000);
      set_mode(1'b0);
      // back on bank 4.
      check_read(16'hD005);
   endtask

   task automatic issue_burst();
      logic [15:0] addr;
      for (int i = 0; i < BURST_LEN; i++) begin
         // alternate fixed and switched windows.
         if (i[0]) begin
            addr = 16'hD000 | {12'd0, i[4:1]};
         end else begin
            addr = 16'hC000 | {12'd0, i[4:1]};
         end
         exp_q.push_back(ref_mem[model_addr(addr)]);
         send_request(addr, 1'b0, 8'h00);
      end
   endtask

   task automatic collect_burst();
      integer     rnd;
      int         got;
      int         waits;
      logic       held;
      logic [7:0] held_data;
      logic [7:0] exp_data;
      got = 0;
      waits = 0;
      held = 1'b0;
      held_data = 8'h00;
      while (got < BURST_LEN) begin
         rnd = $random(seed);
         resp_ready = rnd[0];
         @(negedge i_clk);
         // a stalled response must stay put.
         if (held && !resp_valid) begin
            abort_run("resp_valid dropped before the response was taken");
         end
         if (held) begin
            check_value("resp_rdata", resp_rdata, held_data);
         end
         if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
               abort_run("more responses than requests");
            end
            exp_data = exp_q.pop_front();
            check_value("resp_rdata", resp_rdata, exp_data);
            got++;
            held = 1'b0;
         end else begin
            held = resp_valid;
            held_data = resp_rdata;
         end
         @(posedge i_clk);
         #2;
         waits++;
         if (waits > BURST_LEN * 20) begin
            abort_run("responses of the read burst went missing");
         end
      end
   endtask

   task automatic read_backpressure();
      set_mode(1'b0);
      io_write(`SVBK_ADDR, 8'h03);
      exp_q.delete();
      fork
         issue_burst();
         collect_burst();
      join
      // no extra response after the burst.
      resp_ready = 1'b1;
      repeat (4) begin
         @(negedge i_clk);
         check_value("resp_valid", {7'd0, resp_valid}, 8'h00);
         @(posedge i_clk);
         #2;
      end
   endtask

   initial begin
      seed = 32'h7202adb8;
      tb_bank = bank_t'(0);
      tb_dmg = 1'b0;
      i_clk = 1'b0;
      rst_n = 1'b0;
      io_addr = 16'h0000;
      io_wdata = 8'h00;
      io_we = 1'b0;
      io_re = 1'b0;
      dmg_mode = 1'b0;
      req_valid = 1'b0;
      req_addr = 16'h0000;
      req_we = 1'b0;
      req_wdata = 8'h00;
      resp_ready = 1'b1;
      repeat (16) @(posedge i_clk);
      #2;
      rst_n = 1'b1;
      reset_defaults();
      svbk_readback();
      bank_isolation();
      dmg_bank_lock();
      read_backpressure();
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: hw/gbc_wram_params.svh
`ifndef GBC_WRAM_PARAMS_SVH
`define GBC_WRAM_PARAMS_SVH

// io bus address of the svbk register.
`define SVBK_ADDR 16'hFF70

// number of 4 kb banks in physical storage.
// bank 0 is fixed at 0xc000, banks 1..7 switch in at 0xd000.
`define WRAM_BANKS 8

// total bytes of working ram.
// 8 banks of 4 kb each.
`define WRAM_DEPTH 32768

`endif

// File: hw/gbc_wram_pkg.sv
`include "gbc_wram_params.svh"

package gbc_wram_pkg;

   // bank number as held in svbk.
   // three bits cover all eight banks.
   typedef logic [$clog2(`WRAM_BANKS)-1:0] bank_t;

   // byte address into the physical ram.
   // upper bits pick the bank, lower 12 the offset.
   typedef logic [$clog2(`WRAM_DEPTH)-1:0] phys_addr_t;

   // one working-ram request as taken from the router.
   typedef struct packed {
      // full cpu address, only bits 12:0 matter.
      logic [15:0] addr;
      // high for a write, low for a read.
      logic        we;
      // write byte, don't care on reads.
      logic [7:0]  wdata;
   } wram_req_t;

endpackage

// File: hw/svbk_register.sv
`include "gbc_wram_params.svh"

module svbk_register
   import gbc_wram_pkg::*;
   (
   input  logic        i_clk,
   input  logic        rst_n,

   // io register bus.
   input  logic [15:0] io_addr,
   input  logic [7:0]  io_wdata,
   input  logic        io_we,
   input  logic        io_re,
   output logic [7:0]  io_rdata,

   // dmg mode locks the switchable bank.
   input  logic        dmg_mode,

   // bank as seen by the mapper.
   output bank_t       bank
   );

   logic  svbk_hit;
   logic  svbk_wr;
   bank_t bank_q;

   // address decode for 0xff70.
   assign svbk_hit = (io_addr == `SVBK_ADDR);

   // writes only land in cgb mode.
   assign svbk_wr = io_we & svbk_hit & ~dmg_mode;

   // stored bank, bits 2:0 of the write.
   always_ff @(posedge i_clk or negedge rst_n) begin
      if (!rst_n) begin
         bank_q <= '0;
      end else if (svbk_wr) begin
         bank_q <= io_wdata[$bits(bank_t)-1:0];
      end
   end

   // registered read-back.
   // unused bits read as ones, value holds until the next read.
   always_ff @(posedge i_clk or negedge rst_n) begin
      if (!rst_n) begin
         io_rdata <= '0;
      end else if (io_re && svbk_hit) begin
         io_rdata <= {{(8 - $bits(bank_t)){1'b1}}, bank_q};
      end
   end

   // dmg only ever sees bank 1.
   // the zero-to-one alias is left to the mapper.
   assign bank = dmg_mode ? bank_t'(1) : bank_q;

endmodule

// File: hw/working_memory_bank.sv
module working_memory_bank
   import gbc_wram_pkg::*;
   (
   input  logic        i_clk,
   input  logic        rst_n,

   // io register bus, svbk lives here.
   input  logic [15:0] io_addr,
   input  logic [7:0]  io_wdata,
   input  logic        io_we,
   input  logic        io_re,
   output logic [7:0]  io_rdata,

   // high when running as a dmg.
   input  logic        dmg_mode,

   // wram requests from the router.
   input  logic        req_valid,
   output logic        req_ready,
   input  logic [15:0] req_addr,
   input  logic        req_we,
   input  logic [7:0]  req_wdata,

   // read responses back to the router.
   output logic        resp_valid,
   input  logic        resp_ready,
   output logic [7:0]  resp_rdata
   );

   bank_t      bank;
   phys_addr_t ram_addr;
   logic [7:0] ram_rdata;

   // stage-1 request.
   wram_req_if s1_if ();

   // bank state.
   svbk_register u_svbk (
      .i_clk    (i_clk),
      .rst_n    (rst_n),
      .io_addr  (io_addr),
      .io_wdata (io_wdata),
      .io_we    (io_we),
      .io_re    (io_re),
      .io_rdata (io_rdata),
      .dmg_mode (dmg_mode),
      .bank     (bank)
   );

   // request staging and response queue.
   wram_bus_port u_port (
      .i_clk      (i_clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_addr   (req_addr),
      .req_we     (req_we),
      .req_wdata  (req_wdata),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_rdata (resp_rdata),
      .ram_rdata  (ram_rdata),
      .s1         (s1_if.master)
   );

   // logical to physical.
   wram_bank_mapper u_mapper (
      .bank      (bank),
      .s1        (s1_if.slave),
      .phys_addr (ram_addr)
   );

   // storage, accessed while stage 1 holds a request.
   wram_bram u_ram (
      .i_clk (i_clk),
      .en    (s1_if.s1_valid),
      .we    (s1_if.s1_req.we),
      .addr  (ram_addr),
      .wdata (s1_if.s1_req.wdata),
      .rdata (ram_rdata)
   );

endmodule

// File: hw/wram_bank_mapper.sv
module wram_bank_mapper
   import gbc_wram_pkg::*;
   (
   // bank from svbk, already forced in dmg mode.
   input  bank_t      bank,

   // request in stage 1.
   wram_req_if.slave  s1,

   // byte address into the ram.
   output phys_addr_t phys_addr
   );

   logic [15:0] log_addr;
   bank_t       sel_bank;

   assign log_addr = s1.s1_req.addr;

   // pick the physical bank.
   always_comb begin
      if (!log_addr[12]) begin
         // 0xc000 window, fixed bank 0.
         sel_bank = '0;
      end else if (bank == '0) begin
         // bank 0 in svbk aliases bank 1.
         sel_bank = bank_t'(1);
      end else begin
         sel_bank = bank;
      end
   end

   // bank on top of the 4 kb offset.
   // echo range folds in since bits 15:13 are dropped.
   assign phys_addr = {sel_bank, log_addr[11:0]};

endmodule

// File: hw/wram_bram.sv
`include "gbc_wram_params.svh"

module wram_bram
   import gbc_wram_pkg::*;
   (
   input  logic       i_clk,

   // access strobe and write select.
   input  logic       en,
   input  logic       we,

   input  phys_addr_t addr,
   input  logic [7:0] wdata,

   // read data, one cycle after en.
   output logic [7:0] rdata
   );

   // 8 banks of 4 kb.
   logic [7:0] mem [`WRAM_DEPTH];

   // single port, read returns the old byte on a write.
   always_ff @(posedge i_clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end
         rdata <= mem[addr];
      end
   end

endmodule

// File: hw/wram_bus_port.sv
module wram_bus_port
   import gbc_wram_pkg::*;
   (
   input  logic        i_clk,
   input  logic        rst_n,

   // request channel from the router.
   input  logic        req_valid,
   output logic        req_ready,
   input  logic [15:0] req_addr,
   input  logic        req_we,
   input  logic [7:0]  req_wdata,

   // read response channel.
   output logic        resp_valid,
   input  logic        resp_ready,
   output logic [7:0]  resp_rdata,

   // ram read data, valid the cycle after access.
   input  logic [7:0]  ram_rdata,

   // stage-1 request toward mapper and ram.
   wram_req_if.master  s1
   );

   logic       req_take;
   logic       s1_rd;
   logic       rd_pend;
   logic [7:0] fifo_mem [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] fifo_cnt;
   logic       fifo_empty;
   logic       push;
   logic       pop;
   logic       leaving;
   logic [2:0] in_flight;
   logic [2:0] after_leave;

   assign req_take = req_valid & req_ready;

   // stage 1 register.
   always_ff @(posedge i_clk or negedge rst_n) begin
      if (!rst_n) begin
         s1.s1_valid <= 1'b0;
      end else begin
         s1.s1_valid <= req_take;
      end
   end

   // payload only moves on a transfer.
   always_ff @(posedge i_clk) begin
      if (req_take) begin
         s1.s1_req <= '{addr: req_addr, we: req_we, wdata: req_wdata};
      end
   end

   // read in stage 1 hits the ram at this edge.
   assign s1_rd = s1.s1_valid & ~s1.s1_req.we;

   // ram output cycle marker.
   always_ff @(posedge i_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= s1_rd;
      end
   end

   assign fifo_empty = (fifo_cnt == 2'd0);

   // fresh ram data goes straight out when nothing is queued.
   assign resp_valid = ~fifo_empty | rd_pend;
   assign resp_rdata = fifo_empty ? ram_rdata : fifo_mem[rd_ptr];
   assign leaving    = resp_valid & resp_ready;

   // park ram data unless it bypassed this cycle.
   assign push = rd_pend & ~(fifo_empty & resp_ready);
   assign pop  = ~fifo_empty & resp_ready;

   // two-entry response fifo, pointers and count.
   always_ff @(posedge i_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
         fifo_cnt <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         fifo_cnt <= fifo_cnt + {1'b0, push} - {1'b0, pop};
      end
   end

   // fifo storage.
   always_ff @(posedge i_clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= ram_rdata;
      end
   end

   // reads in stage 1, at the ram output, and queued.
   assign in_flight   = {1'b0, fifo_cnt} + {2'b00, rd_pend} + {2'b00, s1_rd};
   // a response leaving this cycle frees its slot now.
   assign after_leave = in_flight - {2'b00, leaving};

   // room for one more read keeps the total at two.
   assign req_ready = (after_leave < 3'd2);

endmodule

// File: hw/wram_req_if.sv
// stage-1 request between the bus port and the ram side.
interface wram_req_if
   import gbc_wram_pkg::*;
   ();

   // request sits in stage 1 this cycle.
   logic      s1_valid;

   // registered request payload.
   wram_req_t s1_req;

   // bus port owns stage 1.
   modport master (
      output s1_valid,
      output s1_req
   );

   // mapper and ram hookup only look.
   modport slave (
      input s1_valid,
      input s1_req
   );

endinterface

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -j 0 --top-module tb_working_memory_bank \
   -f working_memory_bank.f -o tb_working_memory_bank \
   && ./obj_dir/tb_working_memory_bank | tee sim.log
grep -qsx "TEST PASS" sim.log && echo "run_sim: passed" \
   || { echo "run_sim: failed"; exit 1; }

// File: working_memory_bank.f
+incdir+hw
hw/gbc_wram_pkg.sv
hw/wram_req_if.sv
hw/svbk_register.sv
hw/wram_bus_port.sv
hw/wram_bank_mapper.sv
hw/wram_bram.sv
hw/working_memory_bank.sv
bench/tb_working_memory_bank.sv
